//--- Bender.yml
package:
  name: llc_directory

sources:
  - verilog/llc_geom_pkg.sv
  - verilog/mesi_pkg.sv
  - verilog/line_if.sv
  - verilog/tag_store.sv
  - verilog/plru_tree.sv
  - verilog/stat_counters.sv
  - verilog/mesi_ctrl.sv
  - verilog/llc_top.sv
  - target: simulation
    files:
      - verif/llc_tb.sv

//--- sim.f
verilog/llc_geom_pkg.sv
verilog/mesi_pkg.sv
verilog/line_if.sv
verilog/tag_store.sv
verilog/plru_tree.sv
verilog/stat_counters.sv
verilog/mesi_ctrl.sv
verilog/llc_top.sv
verif/llc_tb.sv

//--- verif/llc_tb.sv
/*
 * Testbench for the cache directory top
 * Reference model of tags, MESI states, PLRU trees and counters
 * Random CPU and snoop traffic plus directed shared-write and clear cases
 */

`timescale 1ns/1ps
`default_nettype none

module llc_tb;
	import llc_geom_pkg::*;
	import mesi_pkg::*;

	localparam int ADDR_BITS    = 32;
	localparam int SET_BITS     = 4;
	localparam int OFFSET_BITS  = 6;
	localparam int TAG_BITS     = ADDR_BITS - SET_BITS - OFFSET_BITS;
	localparam int LINE_BITS    = ADDR_BITS - OFFSET_BITS;
	localparam int SETS         = 1 << SET_BITS;
	localparam int RESET_CYCLES = 10;
	localparam int N_CPU        = 1500;
	localparam int N_SNOOP      = 500;
	localparam int N_DIRECTED   = 40;
	// The mixed run issues one CPU command beside every snoop
	localparam int CYCLE_LIMIT  = RESET_CYCLES + N_CPU + 2 * N_SNOOP + N_DIRECTED + 100;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 cmd_valid;
	cmd_t                 cmd;
	logic [ADDR_BITS-1:0] addr;
	snoop_t               snoop_in;
	logic                 resp_valid;
	logic                 bus_valid;
	bus_op_t              bus_op;
	logic [LINE_BITS-1:0] bus_addr;
	logic                 wb_valid;
	logic [LINE_BITS-1:0] wb_addr;
	logic                 l1_valid;
	l1_msg_t              l1_msg;
	logic [LINE_BITS-1:0] l1_addr;
	logic                 snoop_valid;
	snoop_t               snoop_out;
	count_t               read_count;
	count_t               write_count;
	count_t               hit_count;
	count_t               miss_count;

	integer seed = 32'ha8c7;
	int     errors;
	int     checks;
	int     tests;
	int     cycles = 0;

	// Reference model state
	logic [TAG_BITS-1:0] m_tag   [SETS][WAYS];
	mesi_t               m_state [SETS][WAYS];
	plru_t               m_tree  [SETS];
	count_t              m_reads;
	count_t              m_writes;
	count_t              m_hits;
	count_t              m_misses;

	// Outputs expected one cycle after the last driven command
	logic                 e_resp;
	logic                 e_bus_v;
	bus_op_t              e_bus_op;
	logic [LINE_BITS-1:0] e_bus_addr;
	logic                 e_wb_v;
	logic [LINE_BITS-1:0] e_wb_addr;
	logic                 e_l1_v;
	l1_msg_t              e_l1_msg;
	logic [LINE_BITS-1:0] e_l1_addr;
	logic                 e_snp_v;
	snoop_t               e_snp;

	cmd_t                 cur_cmd;
	snoop_t               cur_snoop;
	logic [ADDR_BITS-1:0] cur_addr;
	logic [LINE_BITS-1:0] first_line;
	int                   errs_at_start;
	int                   pick;

	llc_top #(
		.ADDR_BITS   (ADDR_BITS),
		.SET_BITS    (SET_BITS),
		.OFFSET_BITS (OFFSET_BITS)
	) DUT (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.addr        (addr),
		.snoop_in    (snoop_in),
		.resp_valid  (resp_valid),
		.bus_valid   (bus_valid),
		.bus_op      (bus_op),
		.bus_addr    (bus_addr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.l1_valid    (l1_valid),
		.l1_msg      (l1_msg),
		.l1_addr     (l1_addr),
		.snoop_valid (snoop_valid),
		.snoop_out   (snoop_out),
		.read_count  (read_count),
		.write_count (write_count),
		.hit_count   (hit_count),
		.miss_count  (miss_count)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Tree PLRU model
	// ------------------------------------------------------------------------
	// A node bit of 1 marks the upper half as the older one

	// Walk the older halves from the root down to a leaf
	function automatic way_t plru_victim(input plru_t t);
		way_t v;
		if (t[0] == 1'b0) begin
			if (t[1] == 1'b0)
				v = t[2] ? 3'd1 : 3'd0;
			else
				v = t[3] ? 3'd3 : 3'd2;
		end else begin
			if (t[4] == 1'b0)
				v = t[5] ? 3'd5 : 3'd4;
			else
				v = t[6] ? 3'd7 : 3'd6;
		end
		return v;
	endfunction

	// Every node on the path turns away from the accessed way
	function automatic plru_t plru_touch(input plru_t t, input way_t w);
		plru_t n;
		n = t;
		n[0] = (w < 4);
		if (w < 4) begin
			n[1] = (w < 2);
			if (w < 2)
				n[2] = (w == 0);
			else
				n[3] = (w == 2);
		end else begin
			n[4] = (w < 6);
			if (w < 6)
				n[5] = (w == 4);
			else
				n[6] = (w == 6);
		end
		return n;
	endfunction

	// ------------------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------------------
	task automatic expect_equal(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	// Payloads only carry meaning beside their strobe
	task automatic check_outputs();
		expect_equal("resp_valid", e_resp, resp_valid);
		expect_equal("bus_valid", e_bus_v, bus_valid);
		if (e_bus_v) begin
			expect_equal("bus_op", e_bus_op, bus_op);
			expect_equal("bus_addr", e_bus_addr, bus_addr);
		end
		expect_equal("wb_valid", e_wb_v, wb_valid);
		if (e_wb_v)
			expect_equal("wb_addr", e_wb_addr, wb_addr);
		expect_equal("l1_valid", e_l1_v, l1_valid);
		if (e_l1_v) begin
			expect_equal("l1_msg", e_l1_msg, l1_msg);
			expect_equal("l1_addr", e_l1_addr, l1_addr);
		end
		expect_equal("snoop_valid", e_snp_v, snoop_valid);
		if (e_snp_v)
			expect_equal("snoop_out", e_snp, snoop_out);
		expect_equal("read_count", m_reads, read_count);
		expect_equal("write_count", m_writes, write_count);
		expect_equal("hit_count", m_hits, hit_count);
		expect_equal("miss_count", m_misses, miss_count);
	endtask

	// ------------------------------------------------------------------------
	// Reference model of one command
	// ------------------------------------------------------------------------
	task automatic model_step(input logic valid, input cmd_t c,
		input logic [ADDR_BITS-1:0] a, input snoop_t sn);
		int                   set_i;
		logic [TAG_BITS-1:0]  t;
		logic [LINE_BITS-1:0] la;
		logic                 found;
		way_t                 hw;
		way_t                 vw;
		mesi_t                hs;
		set_i = a[OFFSET_BITS +: SET_BITS];
		t = a[ADDR_BITS-1 -: TAG_BITS];
		la = a[ADDR_BITS-1:OFFSET_BITS];
		e_resp = valid;
		e_bus_v = 1'b0;
		e_wb_v = 1'b0;
		e_l1_v = 1'b0;
		e_snp_v = 1'b0;
		found = 1'b0;
		hw = '0;
		hs = I;
		for (int w = 0; w < WAYS; w++) begin
			if (m_state[set_i][w] != I && m_tag[set_i][w] == t) begin
				found = 1'b1;
				hw = way_t'(w);
				hs = m_state[set_i][w];
			end
		end
		if (valid) begin
			case (c)
				CPU_READ, CPU_WRITE: begin
					if (c == CPU_READ)
						m_reads++;
					else
						m_writes++;
					if (found) begin
						m_hits++;
						if (c == CPU_READ) begin
							e_l1_v = 1'b1;
							e_l1_msg = SENDLINE;
							e_l1_addr = la;
						end else begin
							e_bus_v = (hs == S);
							e_bus_op = INVALIDATE;
							e_bus_addr = la;
							m_state[set_i][hw] = M;
						end
						m_tree[set_i] = plru_touch(m_tree[set_i], hw);
					end else begin
						m_misses++;
						vw = plru_victim(m_tree[set_i]);
						e_bus_v = 1'b1;
						e_bus_addr = la;
						if (c == CPU_READ)
							e_bus_op = READ;
						else
							e_bus_op = RWIM;
						if (m_state[set_i][vw] != I) begin
							e_l1_v = 1'b1;
							e_l1_msg = EVICTLINE;
							e_l1_addr = {m_tag[set_i][vw], SET_BITS'(set_i)};
						end else if (c == CPU_READ) begin
							e_l1_v = 1'b1;
							e_l1_msg = SENDLINE;
							e_l1_addr = la;
						end
						if (m_state[set_i][vw] == M) begin
							e_wb_v = 1'b1;
							e_wb_addr = {m_tag[set_i][vw], SET_BITS'(set_i)};
						end
						m_tag[set_i][vw] = t;
						if (c == CPU_WRITE)
							m_state[set_i][vw] = M;
						else if (sn == HIT || sn == HIT_M)
							m_state[set_i][vw] = S;
						else
							m_state[set_i][vw] = E;
						m_tree[set_i] = plru_touch(m_tree[set_i], vw);
					end
				end

				SNOOP_READ, SNOOP_RDX, SNOOP_INV: begin
					e_snp_v = 1'b1;
					e_snp = NO_HIT;
					if (found) begin
						e_snp = HIT;
						e_l1_addr = la;
						e_bus_addr = la;
						if (c == SNOOP_READ) begin
							m_state[set_i][hw] = S;
							if (hs == M) begin
								e_snp = HIT_M;
								e_bus_v = 1'b1;
								e_bus_op = WRITE;
								e_l1_v = 1'b1;
								e_l1_msg = GETLINE;
							end
						end else begin
							m_state[set_i][hw] = I;
							e_l1_v = 1'b1;
							e_l1_msg = INVALIDATE_LINE;
							if (c == SNOOP_RDX && hs == M) begin
								e_snp = HIT_M;
								e_bus_v = 1'b1;
								e_bus_op = WRITE;
								e_l1_msg = EVICTLINE;
							end
						end
					end
				end

				CLEAR: begin
					for (int s_i = 0; s_i < SETS; s_i++) begin
						m_tree[s_i] = '0;
						for (int w = 0; w < WAYS; w++)
							m_state[s_i][w] = I;
					end
					m_reads = '0;
					m_writes = '0;
					m_hits = '0;
					m_misses = '0;
				end

				default: ;
			endcase
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	// Checks the previous cycle, then drives the next command
	task automatic step(input logic valid, input cmd_t c,
		input logic [ADDR_BITS-1:0] a, input snoop_t sn);
		@(negedge clk);
		check_outputs();
		cmd_valid = valid;
		cmd = c;
		addr = a;
		snoop_in = sn;
		model_step(valid, c, a, sn);
	endtask

	task automatic make_addr(input int tag_idx, input int set_i,
		output logic [ADDR_BITS-1:0] a);
		logic [OFFSET_BITS-1:0] off;
		off = $random(seed);
		a = {TAG_BITS'(tag_idx * 37 + 3), SET_BITS'(set_i), off};
	endtask

	// Small pool of 12 tags over 2 sets keeps hits and evictions frequent
	task automatic random_addr(output logic [ADDR_BITS-1:0] a);
		int tag_idx;
		int set_i;
		tag_idx = $unsigned($random(seed)) % 12;
		set_i = $unsigned($random(seed)) % 2;
		make_addr(tag_idx, set_i, a);
	endtask

	task automatic random_cpu(output cmd_t c, output snoop_t sn);
		int r;
		r = $unsigned($random(seed)) % 3;
		if ($random(seed) & 1)
			c = CPU_WRITE;
		else
			c = CPU_READ;
		case (r)
			0: sn = HIT;
			1: sn = HIT_M;
			default: sn = NO_HIT;
		endcase
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("Test %0d, %s: ok", tests, name);
		else
			$display("Test %0d, %s: %0d errors", tests, name, errors - errs_before);
	endtask

	initial begin
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = CPU_READ;
		addr = '0;
		snoop_in = NO_HIT;
		errors = 0;
		checks = 0;
		tests = 0;
		for (int s_i = 0; s_i < SETS; s_i++) begin
			m_tree[s_i] = '0;
			for (int w = 0; w < WAYS; w++) begin
				m_state[s_i][w] = I;
				m_tag[s_i][w] = '0;
			end
		end
		m_reads = '0;
		m_writes = '0;
		m_hits = '0;
		m_misses = '0;
		e_resp = 1'b0;
		e_bus_v = 1'b0;
		e_bus_op = READ;
		e_bus_addr = '0;
		e_wb_v = 1'b0;
		e_wb_addr = '0;
		e_l1_v = 1'b0;
		e_l1_msg = SENDLINE;
		e_l1_addr = '0;
		e_snp_v = 1'b0;
		e_snp = NO_HIT;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		errs_at_start = errors;
		step(1'b0, CPU_READ, '0, NO_HIT);
		step(1'b0, CPU_READ, '0, NO_HIT);
		finish_test("reset state", errs_at_start);

		errs_at_start = errors;
		repeat (N_CPU) begin
			random_addr(cur_addr);
			random_cpu(cur_cmd, cur_snoop);
			step(1'b1, cur_cmd, cur_addr, cur_snoop);
		end
		step(1'b0, CPU_READ, '0, NO_HIT);
		if (hit_count + miss_count !== N_CPU) begin
			errors++;
			$display("Hit and miss counts do not add up to the CPU accesses");
		end
		finish_test("random CPU reads and writes", errs_at_start);

		// Set 3 stays out of the random pool
		errs_at_start = errors;
		make_addr(0, 3, cur_addr);
		step(1'b1, CPU_READ, cur_addr, HIT);
		step(1'b1, CPU_WRITE, cur_addr, NO_HIT);
		step(1'b1, CPU_WRITE, cur_addr, NO_HIT);
		if (bus_valid !== 1'b1 || bus_op !== INVALIDATE) begin
			errors++;
			$display("Write hit on a shared line did not issue bus INVALIDATE");
		end
		step(1'b0, CPU_READ, '0, NO_HIT);
		if (bus_valid !== 1'b0) begin
			errors++;
			$display("Write hit on a modified line issued a bus operation");
		end
		step(1'b0, CPU_READ, '0, NO_HIT);
		finish_test("write hit on shared line", errs_at_start);

		errs_at_start = errors;
		repeat (N_SNOOP) begin
			random_addr(cur_addr);
			random_cpu(cur_cmd, cur_snoop);
			step(1'b1, cur_cmd, cur_addr, cur_snoop);
			random_addr(cur_addr);
			pick = $unsigned($random(seed)) % 3;
			case (pick)
				0: cur_cmd = SNOOP_READ;
				1: cur_cmd = SNOOP_RDX;
				default: cur_cmd = SNOOP_INV;
			endcase
			step(1'b1, cur_cmd, cur_addr, NO_HIT);
		end
		step(1'b0, CPU_READ, '0, NO_HIT);
		finish_test("snoops mixed with CPU traffic", errs_at_start);

		// Eight fills from a cleared tree cycle through every way back to way 0
		errs_at_start = errors;
		step(1'b1, CLEAR, '0, NO_HIT);
		for (int k = 0; k < 12; k++) begin
			make_addr(k, 0, cur_addr);
			if (k == 0)
				first_line = cur_addr[ADDR_BITS-1:OFFSET_BITS];
			step(1'b1, CPU_READ, cur_addr, NO_HIT);
			if (k == 9) begin
				if (l1_valid !== 1'b1 || l1_msg !== EVICTLINE || l1_addr !== first_line) begin
					errors++;
					$display("First eviction after CLEAR did not take the line in way 0");
				end
			end
		end
		step(1'b0, CPU_READ, '0, NO_HIT);
		if (read_count !== 12 || miss_count !== 12 || hit_count !== 0) begin
			errors++;
			$display("Counts after CLEAR did not restart from zero with all misses");
		end
		step(1'b0, CPU_READ, '0, NO_HIT);
		finish_test("clear then reread", errs_at_start);

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/line_if.sv
/*
 * Lookup and line update path between tag store and coherence controller
 */

`timescale 1ns/1ps
`default_nettype none

interface line_if #(
	parameter int ADDR_BITS   = 32,
	parameter int SET_BITS    = 4,
	parameter int OFFSET_BITS = 6
) ();
	import llc_geom_pkg::*;
	import mesi_pkg::*;

	localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;

	// Lookup, also the set of any update
	logic [SET_BITS-1:0] set;
	logic [TAG_BITS-1:0] tag;

	// Compare result and the PLRU victim's line
	logic                hit;
	way_t                hit_way;
	mesi_t               hit_state;
	logic [TAG_BITS-1:0] victim_tag;
	mesi_t               victim_state;

	logic                upd_en;
	way_t                upd_way;
	logic [TAG_BITS-1:0] upd_tag;
	mesi_t               upd_state;
	logic                clear_all;

	modport store (
		input  set, tag, upd_en, upd_way, upd_tag, upd_state, clear_all,
		output hit, hit_way, hit_state, victim_tag, victim_state
	);

	modport ctrl (
		output set, tag, upd_en, upd_way, upd_tag, upd_state, clear_all,
		input  hit, hit_way, hit_state, victim_tag, victim_state
	);

endinterface

`default_nettype wire

//--- verilog/llc_geom_pkg.sv
/*
 * Cache geometry constants
 * Way index, PLRU tree and statistics count types
 */

`default_nettype none

package llc_geom_pkg;

	// Associativity is fixed by the 7-bit tree PLRU
	localparam int WAYS     = 8;
	localparam int WAY_BITS = 3;

	typedef logic [WAY_BITS-1:0] way_t;

	// One tree per set, node 0 is the root
	typedef logic [WAYS-2:0] plru_t;

	typedef logic [31:0] count_t;

endpackage

`default_nettype wire

//--- verilog/llc_top.sv
/*
 * Last-level cache directory top
 * Tag store, PLRU trees, MESI controller and statistics
 */

`timescale 1ns/1ps
`default_nettype none

module llc_top #(
	parameter int ADDR_BITS   = 32,
	parameter int SET_BITS    = 4,
	parameter int OFFSET_BITS = 6
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             cmd_valid,
	input  mesi_pkg::cmd_t                   cmd,
	input  logic [ADDR_BITS-1:0]             addr,
	input  mesi_pkg::snoop_t                 snoop_in,
	output logic                             resp_valid,
	output logic                             bus_valid,
	output mesi_pkg::bus_op_t                bus_op,
	output logic [ADDR_BITS-OFFSET_BITS-1:0] bus_addr,
	output logic                             wb_valid,
	output logic [ADDR_BITS-OFFSET_BITS-1:0] wb_addr,
	output logic                             l1_valid,
	output mesi_pkg::l1_msg_t                l1_msg,
	output logic [ADDR_BITS-OFFSET_BITS-1:0] l1_addr,
	output logic                             snoop_valid,
	output mesi_pkg::snoop_t                 snoop_out,
	output llc_geom_pkg::count_t             read_count,
	output llc_geom_pkg::count_t             write_count,
	output llc_geom_pkg::count_t             hit_count,
	output llc_geom_pkg::count_t             miss_count
);
	import llc_geom_pkg::*;

	logic [SET_BITS-1:0] plru_set;
	logic                touch_en;
	way_t                touch_way;
	way_t                victim;
	logic                clear_all;
	logic                inc_read;
	logic                inc_write;
	logic                inc_hit;
	logic                inc_miss;

	line_if #(
		.ADDR_BITS   (ADDR_BITS),
		.SET_BITS    (SET_BITS),
		.OFFSET_BITS (OFFSET_BITS)
	) line ();

	// ------------------------------------------------------------------------
	// Directory state
	// ------------------------------------------------------------------------
	tag_store #(
		.ADDR_BITS   (ADDR_BITS),
		.SET_BITS    (SET_BITS),
		.OFFSET_BITS (OFFSET_BITS)
	) u_tag_store (
		.clk    (clk),
		.rst    (rst),
		.line   (line.store),
		.victim (victim)
	);

	plru_tree #(
		.SET_BITS (SET_BITS)
	) u_plru_tree (
		.clk       (clk),
		.rst       (rst),
		.set       (plru_set),
		.touch_en  (touch_en),
		.touch_way (touch_way),
		.clear_all (clear_all),
		.victim    (victim)
	);

	// ------------------------------------------------------------------------
	// Control and statistics
	// ------------------------------------------------------------------------
	mesi_ctrl #(
		.ADDR_BITS   (ADDR_BITS),
		.SET_BITS    (SET_BITS),
		.OFFSET_BITS (OFFSET_BITS)
	) u_mesi_ctrl (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.addr        (addr),
		.snoop_in    (snoop_in),
		.line        (line.ctrl),
		.plru_set    (plru_set),
		.touch_en    (touch_en),
		.touch_way   (touch_way),
		.victim      (victim),
		.clear_all   (clear_all),
		.inc_read    (inc_read),
		.inc_write   (inc_write),
		.inc_hit     (inc_hit),
		.inc_miss    (inc_miss),
		.resp_valid  (resp_valid),
		.bus_valid   (bus_valid),
		.bus_op      (bus_op),
		.bus_addr    (bus_addr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.l1_valid    (l1_valid),
		.l1_msg      (l1_msg),
		.l1_addr     (l1_addr),
		.snoop_valid (snoop_valid),
		.snoop_out   (snoop_out)
	);

	stat_counters u_stat_counters (
		.clk         (clk),
		.rst         (rst),
		.clear_all   (clear_all),
		.inc_read    (inc_read),
		.inc_write   (inc_write),
		.inc_hit     (inc_hit),
		.inc_miss    (inc_miss),
		.read_count  (read_count),
		.write_count (write_count),
		.hit_count   (hit_count),
		.miss_count  (miss_count)
	);

endmodule

`default_nettype wire

//--- verilog/mesi_ctrl.sv
/*
 * MESI coherence controller
 * Decides next line state, bus operation, write-back, L1 message
 * and snoop reply in the command's cycle, and registers the results
 */

`timescale 1ns/1ps
`default_nettype none

module mesi_ctrl #(
	parameter int ADDR_BITS   = 32,
	parameter int SET_BITS    = 4,
	parameter int OFFSET_BITS = 6
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              cmd_valid,
	input  mesi_pkg::cmd_t                    cmd,
	input  logic [ADDR_BITS-1:0]              addr,
	input  mesi_pkg::snoop_t                  snoop_in,
	line_if.ctrl                              line,
	output logic [SET_BITS-1:0]               plru_set,
	output logic                              touch_en,
	output llc_geom_pkg::way_t                touch_way,
	input  llc_geom_pkg::way_t                victim,
	output logic                              clear_all,
	output logic                              inc_read,
	output logic                              inc_write,
	output logic                              inc_hit,
	output logic                              inc_miss,
	output logic                              resp_valid,
	output logic                              bus_valid,
	output mesi_pkg::bus_op_t                 bus_op,
	output logic [ADDR_BITS-OFFSET_BITS-1:0]  bus_addr,
	output logic                              wb_valid,
	output logic [ADDR_BITS-OFFSET_BITS-1:0]  wb_addr,
	output logic                              l1_valid,
	output mesi_pkg::l1_msg_t                 l1_msg,
	output logic [ADDR_BITS-OFFSET_BITS-1:0]  l1_addr,
	output logic                              snoop_valid,
	output mesi_pkg::snoop_t                  snoop_out
);
	import mesi_pkg::*;

	typedef logic [ADDR_BITS-OFFSET_BITS-1:0] line_addr_t;

	line_addr_t line_addr;
	line_addr_t victim_addr;

	logic       nxt_bus_valid;
	bus_op_t    nxt_bus_op;
	logic       nxt_wb_valid;
	logic       nxt_l1_valid;
	l1_msg_t    nxt_l1_msg;
	line_addr_t nxt_l1_addr;
	logic       nxt_snoop_valid;
	snoop_t     nxt_snoop_out;

	// Line address is tag followed by set
	assign line_addr   = addr[ADDR_BITS-1:OFFSET_BITS];
	assign victim_addr = {line.victim_tag, line.set};

	assign line.set     = addr[OFFSET_BITS +: SET_BITS];
	assign line.tag     = addr[ADDR_BITS-1 -: (ADDR_BITS - SET_BITS - OFFSET_BITS)];
	assign line.upd_tag = line.tag;
	assign line.clear_all = clear_all;
	assign plru_set     = line.set;

	// ------------------------------------------------------------------------
	// Decision
	// ------------------------------------------------------------------------
	always_comb begin
		touch_en        = 1'b0;
		touch_way       = line.hit_way;
		clear_all       = 1'b0;
		inc_read        = 1'b0;
		inc_write       = 1'b0;
		inc_hit         = 1'b0;
		inc_miss        = 1'b0;
		line.upd_en     = 1'b0;
		line.upd_way    = line.hit_way;
		line.upd_state  = line.hit_state;
		nxt_bus_valid   = 1'b0;
		nxt_bus_op      = READ;
		nxt_wb_valid    = 1'b0;
		nxt_l1_valid    = 1'b0;
		nxt_l1_msg      = SENDLINE;
		nxt_l1_addr     = line_addr;
		nxt_snoop_valid = 1'b0;
		nxt_snoop_out   = NO_HIT;

		if (cmd_valid) begin
			case (cmd)
				CPU_READ, CPU_WRITE: begin
					inc_read    = (cmd == CPU_READ);
					inc_write   = (cmd == CPU_WRITE);
					touch_en    = 1'b1;
					line.upd_en = 1'b1;
					if (line.hit) begin
						inc_hit = 1'b1;
						if (cmd == CPU_READ) begin
							nxt_l1_valid = 1'b1;
						end else begin
							line.upd_state = M;
							// Other sharers must drop their copy
							nxt_bus_valid = (line.hit_state == S);
							nxt_bus_op    = INVALIDATE;
						end
					end else begin
						inc_miss      = 1'b1;
						touch_way     = victim;
						line.upd_way  = victim;
						nxt_bus_valid = 1'b1;
						if (cmd == CPU_READ) begin
							nxt_bus_op   = READ;
							nxt_l1_valid = 1'b1;
							if (snoop_in == HIT || snoop_in == HIT_M)
								line.upd_state = S;
							else
								line.upd_state = E;
						end else begin
							nxt_bus_op     = RWIM;
							line.upd_state = M;
						end
						// Eviction message takes the place of SENDLINE
						if (line.victim_state != I) begin
							nxt_l1_valid = 1'b1;
							nxt_l1_msg   = EVICTLINE;
							nxt_l1_addr  = victim_addr;
						end
						nxt_wb_valid = (line.victim_state == M);
					end
				end

				SNOOP_READ, SNOOP_RDX, SNOOP_INV: begin
					nxt_snoop_valid = 1'b1;
					if (line.hit) begin
						line.upd_en   = 1'b1;
						nxt_snoop_out = HIT;
						if (cmd == SNOOP_READ) begin
							line.upd_state = S;
							if (line.hit_state == M) begin
								nxt_snoop_out = HIT_M;
								nxt_bus_valid = 1'b1;
								nxt_bus_op    = WRITE;
								nxt_l1_valid  = 1'b1;
								nxt_l1_msg    = GETLINE;
							end
						end else begin
							line.upd_state = I;
							nxt_l1_valid   = 1'b1;
							nxt_l1_msg     = INVALIDATE_LINE;
							if (cmd == SNOOP_RDX && line.hit_state == M) begin
								nxt_snoop_out = HIT_M;
								nxt_bus_valid = 1'b1;
								nxt_bus_op    = WRITE;
								nxt_l1_msg    = EVICTLINE;
							end
						end
					end
				end

				CLEAR: clear_all = 1'b1;

				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Response registers, one cycle after cmd_valid
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid  <= 1'b0;
			bus_valid   <= 1'b0;
			wb_valid    <= 1'b0;
			l1_valid    <= 1'b0;
			snoop_valid <= 1'b0;
		end else begin
			resp_valid  <= cmd_valid;
			bus_valid   <= nxt_bus_valid;
			wb_valid    <= nxt_wb_valid;
			l1_valid    <= nxt_l1_valid;
			snoop_valid <= nxt_snoop_valid;
		end
	end

	// Payloads load only with their strobe
	always_ff @(posedge clk) begin
		if (nxt_bus_valid) begin
			bus_op   <= nxt_bus_op;
			bus_addr <= line_addr;
		end
		if (nxt_wb_valid)
			wb_addr <= victim_addr;
		if (nxt_l1_valid) begin
			l1_msg  <= nxt_l1_msg;
			l1_addr <= nxt_l1_addr;
		end
		if (nxt_snoop_valid)
			snoop_out <= nxt_snoop_out;
	end

endmodule

`default_nettype wire

//--- verilog/mesi_pkg.sv
/*
 * Command, MESI state, bus operation, snoop result
 * and L1 message encodings
 */

`default_nettype none

package mesi_pkg;

	typedef enum logic [2:0] {
		CPU_READ   = 3'd0,
		CPU_WRITE  = 3'd1,
		SNOOP_INV  = 3'd3,
		SNOOP_READ = 3'd4,
		SNOOP_RDX  = 3'd6,
		CLEAR      = 3'd7
	} cmd_t;

	// I must stay at zero, it is the reset state of every line
	typedef enum logic [1:0] {
		I = 2'd0,
		S = 2'd1,
		E = 2'd2,
		M = 2'd3
	} mesi_t;

	typedef enum logic [1:0] {
		READ       = 2'd0,
		WRITE      = 2'd1,
		INVALIDATE = 2'd2,
		RWIM       = 2'd3
	} bus_op_t;

	typedef enum logic [1:0] {
		HIT    = 2'd0,
		HIT_M  = 2'd1,
		NO_HIT = 2'd2
	} snoop_t;

	typedef enum logic [1:0] {
		GETLINE         = 2'd0,
		SENDLINE        = 2'd1,
		INVALIDATE_LINE = 2'd2,
		EVICTLINE       = 2'd3
	} l1_msg_t;

endpackage

`default_nettype wire

//--- verilog/plru_tree.sv
/*
 * Tree pseudo-LRU, one 7-bit tree per set
 * Victim walk and access update
 */

`timescale 1ns/1ps
`default_nettype none

module plru_tree #(
	parameter int SET_BITS = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [SET_BITS-1:0] set,
	input  logic                touch_en,
	input  llc_geom_pkg::way_t  touch_way,
	input  logic                clear_all,
	output llc_geom_pkg::way_t  victim
);
	import llc_geom_pkg::*;

	localparam int SETS = 1 << SET_BITS;

	// Bit 0 is the root. Bits 1-3 form the subtree of ways 0-3, bits 4-6
	// the subtree of ways 4-7: subtree node first, then one bit per pair.
	// A bit of 0 points at the lower half as the older one.
	plru_t tree [SETS];
	plru_t cur;
	plru_t touched;

	assign cur = tree[set];

	always_comb begin
		int vb;
		logic pair;
		vb = cur[0] ? 4 : 1;
		pair = cur[vb];
		victim = {cur[0], pair, pair ? cur[vb + 2] : cur[vb + 1]};
	end

	// Every node on the accessed way's path turns to the other half
	always_comb begin
		int tb;
		tb = touch_way[2] ? 4 : 1;
		touched = cur;
		touched[0] = ~touch_way[2];
		touched[tb] = ~touch_way[1];
		touched[tb + 1 + int'(touch_way[1])] = ~touch_way[0];
	end

	always_ff @(posedge clk) begin
		if (rst || clear_all) begin
			for (int s = 0; s < SETS; s++) begin
				tree[s] <= '0;
			end
		end else if (touch_en) begin
			tree[set] <= touched;
		end
	end

endmodule

`default_nettype wire

//--- verilog/stat_counters.sv
/*
 * Read, write, hit and miss counters
 */

`timescale 1ns/1ps
`default_nettype none

module stat_counters (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 clear_all,
	input  logic                 inc_read,
	input  logic                 inc_write,
	input  logic                 inc_hit,
	input  logic                 inc_miss,
	output llc_geom_pkg::count_t read_count,
	output llc_geom_pkg::count_t write_count,
	output llc_geom_pkg::count_t hit_count,
	output llc_geom_pkg::count_t miss_count
);

	always_ff @(posedge clk) begin
		if (rst || clear_all) begin
			read_count  <= '0;
			write_count <= '0;
			hit_count   <= '0;
			miss_count  <= '0;
		end else begin
			if (inc_read)
				read_count <= read_count + 1'b1;
			if (inc_write)
				write_count <= write_count + 1'b1;
			if (inc_hit)
				hit_count <= hit_count + 1'b1;
			if (inc_miss)
				miss_count <= miss_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tag_store.sv
/*
 * Tag and MESI state arrays
 * Parallel compare over all ways, one-way write port
 */

`timescale 1ns/1ps
`default_nettype none

module tag_store #(
	parameter int ADDR_BITS   = 32,
	parameter int SET_BITS    = 4,
	parameter int OFFSET_BITS = 6
) (
	input  logic               clk,
	input  logic               rst,
	line_if.store              line,
	input  llc_geom_pkg::way_t victim
);
	import llc_geom_pkg::*;
	import mesi_pkg::*;

	localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;
	localparam int SETS     = 1 << SET_BITS;

	typedef logic [TAG_BITS-1:0] tag_t;

	tag_t  tag_mem   [SETS][WAYS];
	mesi_t state_mem [SETS][WAYS];

	// States are the only thing a clear touches, stale tags stay behind
	always_ff @(posedge clk) begin
		if (rst || line.clear_all) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					state_mem[s][w] <= I;
				end
			end
		end else if (line.upd_en) begin
			state_mem[line.set][line.upd_way] <= line.upd_state;
		end
	end

	always_ff @(posedge clk) begin
		if (line.upd_en) begin
			tag_mem[line.set][line.upd_way] <= line.upd_tag;
		end
	end

	// An invalid way never hits, whatever its tag holds
	always_comb begin
		line.hit       = 1'b0;
		line.hit_way   = '0;
		line.hit_state = I;
		for (int w = 0; w < WAYS; w++) begin
			if (state_mem[line.set][w] != I && tag_mem[line.set][w] == line.tag) begin
				line.hit       = 1'b1;
				line.hit_way   = way_t'(w);
				line.hit_state = state_mem[line.set][w];
			end
		end
	end

	assign line.victim_tag   = tag_mem[line.set][victim];
	assign line.victim_state = state_mem[line.set][victim];

endmodule

`default_nettype wire
